/* verilog/vga_pkg.sv */
package vga_pkg;

  // one raster position as it moves down the pipeline
  typedef struct packed {
    logic [11:0] hcount;
    logic [11:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
  } timing_t;

  // host-written cursor and background settings
  typedef struct packed {
    logic [11:0] xpos;
    logic [11:0] ypos;
    logic        enable;
    logic [11:0] cursor_rgb;
    logic [3:0]  bg_tint;
  } cursor_cfg_t;

  // cursor painter verdict for one pixel
  typedef struct packed {
    logic        hit;
    logic [11:0] rgb;
  } cursor_px_t;

  // APB register offsets
  localparam logic [7:0] ADDR_XPOS = 8'h00;
  localparam logic [7:0] ADDR_YPOS = 8'h04;
  localparam logic [7:0] ADDR_CTRL = 8'h08;
  localparam logic [7:0] ADDR_TINT = 8'h0c;

  // side of the arrow triangle in pixels
  localparam int CURSOR_SIZE = 16;

endpackage

/* verilog/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29
) (
  input  logic    pclk,
  input  logic    rst_n,
  output timing_t timing
);

  localparam logic [11:0] H_LAST       = 12'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam logic [11:0] H_SYNC_START = 12'(H_ACTIVE + H_FP);
  localparam logic [11:0] H_SYNC_END   = 12'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [11:0] V_LAST       = 12'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);
  localparam logic [11:0] V_SYNC_START = 12'(V_ACTIVE + V_FP);
  localparam logic [11:0] V_SYNC_END   = 12'(V_ACTIVE + V_FP + V_SYNC);

  timing_t timing_nxt;
  logic    line_end;

  assign line_end = (timing.hcount == H_LAST);

  always_comb begin
    timing_nxt.hcount = line_end ? 12'd0 : timing.hcount + 12'd1;
    if (line_end) begin
      timing_nxt.vcount = (timing.vcount == V_LAST) ? 12'd0 : timing.vcount + 12'd1;
    end else begin
      timing_nxt.vcount = timing.vcount;
    end
    // flags follow the new counts so they land in the same register stage
    timing_nxt.hblnk = (timing_nxt.hcount >= 12'(H_ACTIVE));
    timing_nxt.vblnk = (timing_nxt.vcount >= 12'(V_ACTIVE));
    timing_nxt.hsync = !((timing_nxt.hcount >= H_SYNC_START) &&
                         (timing_nxt.hcount < H_SYNC_END));
    timing_nxt.vsync = !((timing_nxt.vcount >= V_SYNC_START) &&
                         (timing_nxt.vcount < V_SYNC_END));
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      // park on the last position so the first run edge lands on 0,0
      timing.hcount <= H_LAST;
      timing.vcount <= V_LAST;
      timing.hsync  <= 1'b1;
      timing.vsync  <= 1'b1;
      timing.hblnk  <= 1'b1;
      timing.vblnk  <= 1'b1;
    end else begin
      timing <= timing_nxt;
    end
  end

endmodule

/* verilog/draw_background.sv */
`timescale 1ns/1ps

module draw_background
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768
) (
  input  logic        pclk,
  input  logic        rst_n,
  input  timing_t     timing_in,
  input  cursor_cfg_t cfg,
  output timing_t     timing_out,
  output logic [11:0] bg_rgb
);

  localparam logic [11:0] H_LAST_COL = 12'(H_ACTIVE - 1);
  localparam logic [11:0] V_LAST_ROW = 12'(V_ACTIVE - 1);

  logic        border;
  logic [11:0] rgb_nxt;

  // outer frame of the active area
  assign border = (timing_in.hcount == 12'd0) || (timing_in.hcount == H_LAST_COL) ||
                  (timing_in.vcount == 12'd0) || (timing_in.vcount == V_LAST_ROW);

  // red ramps across, green ramps down, blue from the host tint
  assign rgb_nxt = border ? 12'hfff
                          : {timing_in.hcount[5:2], timing_in.vcount[5:2], cfg.bg_tint};

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      timing_out.hcount <= 12'd0;
      timing_out.vcount <= 12'd0;
      timing_out.hsync  <= 1'b1;
      timing_out.vsync  <= 1'b1;
      timing_out.hblnk  <= 1'b1;
      timing_out.vblnk  <= 1'b1;
    end else begin
      timing_out <= timing_in;
    end
  end

  always_ff @(posedge pclk) begin
    bg_rgb <= rgb_nxt;
  end

endmodule

/* verilog/draw_cursor.sv */
`timescale 1ns/1ps

module draw_cursor
  import vga_pkg::*;
(
  input  logic        pclk,
  input  logic        rst_n,
  input  timing_t     timing_in,
  input  cursor_cfg_t cfg,
  output cursor_px_t  cursor_px
);

  // one extra bit keeps positions left of or above the cursor negative
  logic [12:0] dx;
  logic [12:0] dy;
  logic        dx_in;
  logic        dy_in;
  logic        hit_nxt;

  assign dx = {1'b0, timing_in.hcount} - {1'b0, cfg.xpos};
  assign dy = {1'b0, timing_in.vcount} - {1'b0, cfg.ypos};

  assign dx_in = !dx[12] && (dx < 13'(CURSOR_SIZE));
  assign dy_in = !dy[12] && (dy < 13'(CURSOR_SIZE));

  // lower-left half of the box gives the arrow triangle
  assign hit_nxt = cfg.enable && dx_in && dy_in && (dx <= dy);

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      cursor_px.hit <= 1'b0;
    end else begin
      cursor_px.hit <= hit_nxt;
    end
  end

  // colour rides along with the hit
  always_ff @(posedge pclk) begin
    cursor_px.rgb <= cfg.cursor_rgb;
  end

endmodule

/* verilog/pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer
  import vga_pkg::*;
(
  input  logic        pclk,
  input  logic        rst_n,
  input  timing_t     timing_in,
  input  logic [11:0] bg_rgb,
  input  cursor_px_t  cursor_px,
  output logic        hs,
  output logic        vs,
  output logic [3:0]  r,
  output logic [3:0]  g,
  output logic [3:0]  b
);

  logic [11:0] rgb_nxt;

  always_comb begin
    if (timing_in.hblnk || timing_in.vblnk) begin
      rgb_nxt = 12'h000;
    end else if (cursor_px.hit) begin
      rgb_nxt = cursor_px.rgb;
    end else begin
      rgb_nxt = bg_rgb;
    end
  end

  // pin register, syncs idle high
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hs        <= 1'b1;
      vs        <= 1'b1;
      {r, g, b} <= 12'h000;
    end else begin
      hs        <= timing_in.hsync;
      vs        <= timing_in.vsync;
      {r, g, b} <= rgb_nxt;
    end
  end

endmodule

/* verilog/cursor_regs.sv */
`timescale 1ns/1ps

module cursor_regs
  import vga_pkg::*;
(
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output cursor_cfg_t cfg
);

  logic addr_ok;
  logic access;
  logic wr_en;

  assign addr_ok = (paddr == ADDR_XPOS) || (paddr == ADDR_YPOS) ||
                   (paddr == ADDR_CTRL) || (paddr == ADDR_TINT);

  assign access  = psel && penable;
  assign wr_en   = access && pwrite && addr_ok;

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access && !addr_ok;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (paddr)
        ADDR_XPOS: cfg.xpos <= pwdata[11:0];
        ADDR_YPOS: cfg.ypos <= pwdata[11:0];
        ADDR_CTRL: begin
          cfg.enable     <= pwdata[12];
          cfg.cursor_rgb <= pwdata[11:0];
        end
        ADDR_TINT: cfg.bg_tint <= pwdata[3:0];
        default: ;
      endcase
    end
  end

  // read mux, unused bits and unknown offsets read zero
  always_comb begin
    prdata = 32'd0;
    case (paddr)
      ADDR_XPOS: prdata[11:0] = cfg.xpos;
      ADDR_YPOS: prdata[11:0] = cfg.ypos;
      ADDR_CTRL: prdata[12:0] = {cfg.enable, cfg.cursor_rgb};
      ADDR_TINT: prdata[3:0]  = cfg.bg_tint;
      default:   prdata       = 32'd0;
    endcase
  end

endmodule

/* verilog/vga_top.sv */
`timescale 1ns/1ps

module vga_top
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29
) (
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        hs,
  output logic        vs,
  output logic [3:0]  r,
  output logic [3:0]  g,
  output logic [3:0]  b
);

  cursor_cfg_t cfg;
  timing_t     timing_raw;
  timing_t     timing_bg;
  logic [11:0] bg_rgb;
  cursor_px_t  cursor_px;

  cursor_regs u_regs (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) u_timing (
    .pclk   (pclk),
    .rst_n  (rst_n),
    .timing (timing_raw)
  );

  // both painters see the same position in the same cycle
  draw_background #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_background (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .timing_in  (timing_raw),
    .cfg        (cfg),
    .timing_out (timing_bg),
    .bg_rgb     (bg_rgb)
  );

  draw_cursor u_cursor (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .timing_in (timing_raw),
    .cfg       (cfg),
    .cursor_px (cursor_px)
  );

  pixel_mixer u_mixer (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .timing_in (timing_bg),
    .bg_rgb    (bg_rgb),
    .cursor_px (cursor_px),
    .hs        (hs),
    .vs        (vs),
    .r         (r),
    .g         (g),
    .b         (b)
  );

endmodule

/* tests/vga_tb.sv */
`timescale 1ns/1ps

module vga_tb
  import vga_pkg::*;
();

  // tiny raster, 80 by 54 cycles per frame
  localparam int H_ACTIVE = 64;
  localparam int H_FP = 4;
  localparam int H_SYNC = 8;
  localparam int H_BP = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FP = 2;
  localparam int V_SYNC = 2;
  localparam int V_BP = 2;
  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int CLK_PERIOD = 20;
  localparam int WATCHDOG_TIME = (6 * H_TOTAL * V_TOTAL + 1000) * CLK_PERIOD;
  localparam int APB_MAX_WAIT = 8;

  logic        pclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        hs;
  logic        vs;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;

  integer      seed;
  cursor_cfg_t cfg_m;
  logic        check_on;
  logic        m_on;
  int          fill;
  int          mh;
  int          mv;
  string       cur_test;
  string       pix_name;
  int          pix_errs;
  int          bus_errs;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;

  vga_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) UUT (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hs      (hs),
    .vs      (vs),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Error: watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [11:0] model_pixel(input int h, input int v, input cursor_cfg_t c);
    int          dx;
    int          dy;
    logic [11:0] hv;
    logic [11:0] vv;
    dx = h - int'(c.xpos);
    dy = v - int'(c.ypos);
    hv = 12'(h);
    vv = 12'(v);
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      return 12'h000;
    end
    if (c.enable && dx >= 0 && dy >= 0 && dx < CURSOR_SIZE && dy < CURSOR_SIZE && dx <= dy) begin
      return c.cursor_rgb;
    end
    if (h == 0 || h == H_ACTIVE - 1 || v == 0 || v == V_ACTIVE - 1) begin
      return 12'hfff;
    end
    return {hv[5:2], vv[5:2], c.bg_tint};
  endfunction

  // {hs, vs}, both active low
  function automatic logic [1:0] model_sync(input int h, input int v);
    logic hs_exp;
    logic vs_exp;
    hs_exp = !(h >= H_ACTIVE + H_FP && h < H_ACTIVE + H_FP + H_SYNC);
    vs_exp = !(v >= V_ACTIVE + V_FP && v < V_ACTIVE + V_FP + V_SYNC);
    return {hs_exp, vs_exp};
  endfunction

  task automatic check_rgb(input string name, input logic [11:0] exp, input logic [11:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected rgb %03h, actual %03h", name, exp, act);
      pix_errs++;
    end
  endtask

  task automatic check_sync(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected hs,vs %02b, actual %02b", name, exp, act);
      pix_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %08h, actual %08h", name, exp, act);
      bus_errs++;
    end
  endtask

  // position now on the pins, two register stages behind the counters
  always @(posedge pclk) begin
    if (!rst_n) begin
      fill <= 0;
      m_on <= 1'b0;
      mh   <= 0;
      mv   <= 0;
    end else if (!m_on) begin
      if (fill == 2) begin
        m_on <= 1'b1;
      end else begin
        fill <= fill + 1;
      end
    end else if (mh == H_TOTAL - 1) begin
      mh <= 0;
      mv <= (mv == V_TOTAL - 1) ? 0 : mv + 1;
    end else begin
      mh <= mh + 1;
    end
  end

  always @(negedge pclk) begin
    if (check_on && m_on) begin
      pix_name = $sformatf("%s pixel %0d,%0d", cur_test, mh, mv);
      check_sync(pix_name, model_sync(mh, mv), {hs, vs});
      check_rgb(pix_name, model_pixel(mh, mv, cfg_m), {r, g, b});
    end else if (check_on) begin
      check_sync("reset_idle", 2'b11, {hs, vs});
      check_rgb("reset_idle", 12'h000, {r, g, b});
    end
  end

  // one APB transfer; for a read, data is the expected word
  task automatic reg_op(input logic write, input logic [7:0] addr, input logic [31:0] data,
                        input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    waits   = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = write ? data : 32'd0;
    @(negedge pclk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    while (!pready && waits < APB_MAX_WAIT) begin
      @(negedge pclk);
      #(CLK_PERIOD / 4);
      waits++;
    end
    if (!pready) begin
      $display("Error: %s: pready never came high at address %02h", cur_test, addr);
      bus_errs++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (err !== exp_err) begin
      $display("Error: %s: pslverr was %b at address %02h, should be %b",
               cur_test, err, addr, exp_err);
      bus_errs++;
    end
    if (!write) begin
      check_word($sformatf("%s read %02h", cur_test, addr), data, rdata);
    end else if (!exp_err) begin
      case (addr)
        ADDR_XPOS: cfg_m.xpos = data[11:0];
        ADDR_YPOS: cfg_m.ypos = data[11:0];
        ADDR_CTRL: begin
          cfg_m.enable     = data[12];
          cfg_m.cursor_rgb = data[11:0];
        end
        ADDR_TINT: cfg_m.bg_tint = data[3:0];
        default: ;
      endcase
    end
  endtask

  task automatic set_cursor(input int x, input int y, input logic en, input logic [11:0] rgb,
                            input logic [3:0] tint);
    reg_op(1'b1, ADDR_XPOS, 32'(x), 1'b0);
    reg_op(1'b1, ADDR_YPOS, 32'(y), 1'b0);
    reg_op(1'b1, ADDR_CTRL, {19'd0, en, rgb}, 1'b0);
    reg_op(1'b1, ADDR_TINT, {28'd0, tint}, 1'b0);
  endtask

  // returns when the pins reach the first vertical blanking line
  task automatic wait_vblank();
    do begin
      @(negedge pclk);
    end while (!(m_on && mv == V_ACTIVE && mh == 0));
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = pix_errs + bus_errs;
  endtask

  task automatic finish_test();
    int errs;
    errs = pix_errs + bus_errs - test_err_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errs);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] wx;
    logic [31:0] wy;
    logic [31:0] wc;
    logic [31:0] wt;
    logic [7:0]  bad;
    logic [3:0]  tint;
    int          x;
    int          y;
    seed         = 32'h9ae1;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 8'h00;
    pwdata       = 32'd0;
    cfg_m        = '0;
    check_on     = 1'b0;
    pix_errs     = 0;
    bus_errs     = 0;
    tests_run    = 0;
    tests_failed = 0;
    start_test("reset_and_sync");
    @(posedge pclk);
    check_on = 1'b1;
    repeat (4) @(negedge pclk);
    rst_n = 1'b1;
    wait_vblank();
    finish_test();

    start_test("register_access");
    wx  = $random(seed);
    wy  = $random(seed);
    wc  = $random(seed);
    wt  = $random(seed);
    bad = 8'($random(seed)) | 8'h10;
    reg_op(1'b1, ADDR_XPOS, wx, 1'b0);
    reg_op(1'b1, ADDR_YPOS, wy, 1'b0);
    reg_op(1'b1, ADDR_CTRL, wc, 1'b0);
    reg_op(1'b1, ADDR_TINT, wt, 1'b0);
    reg_op(1'b0, ADDR_XPOS, wx & 32'hfff, 1'b0);
    reg_op(1'b0, ADDR_YPOS, wy & 32'hfff, 1'b0);
    reg_op(1'b0, ADDR_CTRL, wc & 32'h1fff, 1'b0);
    reg_op(1'b0, ADDR_TINT, wt & 32'hf, 1'b0);
    reg_op(1'b1, bad, $random(seed), 1'b1);
    reg_op(1'b0, bad, 32'd0, 1'b1);
    // the rejected write must leave every register alone
    reg_op(1'b0, ADDR_XPOS, wx & 32'hfff, 1'b0);
    reg_op(1'b0, ADDR_YPOS, wy & 32'hfff, 1'b0);
    reg_op(1'b0, ADDR_CTRL, wc & 32'h1fff, 1'b0);
    reg_op(1'b0, ADDR_TINT, wt & 32'hf, 1'b0);
    finish_test();

    start_test("background_tint");
    tint = 4'($random(seed));
    set_cursor(rand_below(H_ACTIVE), rand_below(V_ACTIVE), 1'b0, 12'($random(seed)), tint);
    wait_vblank();
    finish_test();

    start_test("cursor_placement");
    x = rand_below(H_ACTIVE - CURSOR_SIZE);
    y = rand_below(V_ACTIVE - CURSOR_SIZE);
    set_cursor(x, y, 1'b1, 12'($random(seed)), tint);
    wait_vblank();
    // near the bottom right corner the triangle is cut off by blanking
    set_cursor(H_ACTIVE - 1 - rand_below(8), V_ACTIVE - 1 - rand_below(8), 1'b1,
               12'($random(seed)), tint);
    wait_vblank();
    finish_test();

    start_test("cursor_move");
    x = rand_below(H_ACTIVE);
    y = rand_below(V_ACTIVE);
    set_cursor(x, y, 1'b1, 12'($random(seed)), tint);
    wait_vblank();
    set_cursor((x + 1 + rand_below(H_ACTIVE - 1)) % H_ACTIVE, rand_below(V_ACTIVE), 1'b1,
               12'($random(seed)), tint);
    wait_vblank();
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             pix_errs + bus_errs);
    if (tests_failed == 0 && pix_errs + bus_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_background.sv
verilog/draw_cursor.sv
verilog/pixel_mixer.sv
verilog/cursor_regs.sv
verilog/vga_top.sv
tests/vga_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := vga_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := PASS: all tests

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
